/* vlog.f */
common/audio_pkg.sv
hdl/audio_reg_decode.sv
audio_channel/audio_channel.sv
hdl/audio_dma_arbiter.sv
hdl/audio_mixer.sv
hdl/audio_controller.sv
tb/audio_chk.sv
tb/tb_audio.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_audio -f vlog.f -o tb_audio

./obj_dir/tb_audio > sim.log 2>&1 || true
cat sim.log

grep -qF "** PASS **" sim.log

/* tb/tb_audio.sv */
`timescale 1ns/1ps

module tb_audio import audio_pkg::*; ();

	localparam int STROBE_GAP = 40;
	localparam int READY_LIMIT = 20;
	// Strobes, settle waits and CPU accesses over all five tests
	localparam int NUM_STROBES = 8 + 7 + 8;
	localparam int NUM_SETTLES = 4;
	localparam int NUM_ACCESSES = 45;
	localparam int CYCLE_LIMIT = NUM_STROBES * (STROBE_GAP + 4) + NUM_SETTLES * STROBE_GAP
		+ NUM_ACCESSES * 8 + 500;

	logic i_clock;
	logic i_rst;
	logic i_request;
	logic i_rw;
	reg_addr_t i_address;
	word_t i_wdata;
	word_t o_rdata;
	logic o_ready;
	logic o_dma_request;
	word_t o_dma_address;
	logic i_dma_ready;
	word_t i_dma_rdata;
	logic i_output_sample_clock;
	word_t o_output_sample_rate;
	sample_t o_output_sample_left;
	sample_t o_output_sample_right;

	// Reference model state per channel
	word_t m_addr [NUM_CHANNELS];
	int m_rem [NUM_CHANNELS];
	volume_t m_vol [NUM_CHANNELS];
	word_t dma_base [NUM_CHANNELS];
	word_t dma_next [NUM_CHANNELS];
	word_t dma_end [NUM_CHANNELS];
	logic range_check;
	int mem_delay;
	int cycles;
	int checks;
	int errors;

	audio_controller u_dut (.*);

	always #2 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic word_t mem_word(input word_t addr);
		logic [15:0] low;
		low = addr[17:2];
		return {~low, low};
	endfunction

	function automatic int scale(input sample_t s, input volume_t v);
		int p;
		p = int'(s) * int'(v);
		return p >>> 4;
	endfunction

	function automatic chan_mask_t model_busy();
		chan_mask_t m;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			m[c] = (m_rem[c] > 0);
		end
		return m;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// Each fetch must hit its own channel's range, one word after the last
	task automatic track_dma(input word_t addr);
		int hit;
		hit = -1;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			if (addr >= dma_base[c] && addr < dma_end[c]) begin
				hit = c;
			end
		end
		if (hit < 0) begin
			errors++;
			$display("DMA read at %h lies outside every programmed range", addr);
		end else begin
			check_word("o_dma_address", addr, dma_next[hit]);
			dma_next[hit] += 4;
		end
	endtask

	// Memory answers after 0 to 3 wait cycles
	always @(posedge i_clock) begin
		if (i_rst || i_dma_ready) begin
			i_dma_ready <= 1'b0;
			mem_delay = -1;
		end else if (o_dma_request) begin
			if (mem_delay < 0) begin
				mem_delay = $urandom % 4;
			end
			if (mem_delay == 0) begin
				i_dma_ready <= 1'b1;
				i_dma_rdata <= mem_word(o_dma_address);
				if (range_check) begin
					track_dma(o_dma_address);
				end
			end
			mem_delay--;
		end
	end

	task automatic cpu_access(input logic rw, input reg_addr_t addr, input word_t wdata,
			output word_t rdata);
		int waited;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= rw;
		i_address <= addr;
		i_wdata <= wdata;
		waited = 0;
		do begin
			@(posedge i_clock);
			waited++;
		end while (!o_ready && waited < READY_LIMIT);
		if (!o_ready) begin
			errors++;
			$display("CPU access to address %h was never acknowledged", addr);
		end
		rdata = o_rdata;
		i_request <= 1'b0;
		do begin
			@(posedge i_clock);
			waited++;
		end while (o_ready && waited < 2 * READY_LIMIT);
		if (o_ready) begin
			errors++;
			$display("o_ready stayed high after the request to address %h dropped", addr);
		end
	endtask

	task automatic cpu_write(input reg_addr_t addr, input word_t wdata);
		word_t unused;
		cpu_access(1'b1, addr, wdata, unused);
	endtask

	task automatic cpu_read(input reg_addr_t addr, output word_t rdata);
		cpu_access(1'b0, addr, '0, rdata);
	endtask

	task automatic setup_channel(input int c, input word_t addr, input int count,
			input volume_t vol);
		cpu_write(reg_addr_t'(4 * c + REG_CH_ADDR), addr);
		cpu_write(reg_addr_t'(4 * c + REG_CH_VOLUME), word_t'(vol));
		m_vol[c] = vol;
		m_addr[c] = addr;
		m_rem[c] = count;
		dma_base[c] = addr;
		dma_next[c] = addr;
		dma_end[c] = addr + 4 * count;
		// The count write starts the channel
		cpu_write(reg_addr_t'(4 * c + REG_CH_COUNT), word_t'(count));
	endtask

	task automatic play_strobe();
		int sum_left;
		int sum_right;
		word_t w;
		sum_left = 0;
		sum_right = 0;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			if (m_rem[c] > 0) begin
				w = mem_word(m_addr[c]);
				sum_left += scale(sample_t'(w[15:0]), m_vol[c]);
				sum_right += scale(sample_t'(w[31:16]), m_vol[c]);
				m_addr[c] += 4;
				m_rem[c]--;
			end
		end
		@(posedge i_clock);
		i_output_sample_clock <= 1'b1;
		@(posedge i_clock);
		i_output_sample_clock <= 1'b0;
		// Mixer output settles two edges after the strobe
		@(posedge i_clock);
		@(negedge i_clock);
		check_sample("o_output_sample_left", o_output_sample_left, sample_t'(sum_left));
		check_sample("o_output_sample_right", o_output_sample_right, sample_t'(sum_right));
		repeat (STROBE_GAP) @(posedge i_clock);
	endtask

	task automatic end_test(input string name, input int err_mark);
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_mark);
		end
	endtask

	initial begin
		word_t rd;
		word_t rate;
		int c;
		int count;
		int err_mark;
		void'($urandom(32'ha5773acd));
		i_clock = 1'b0;
		i_rst = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_dma_ready = 1'b0;
		i_dma_rdata = '0;
		i_output_sample_clock = 1'b0;
		range_check = 1'b0;
		mem_delay = -1;
		cycles = 0;
		checks = 0;
		errors = 0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			m_addr[k] = '0;
			m_rem[k] = 0;
			m_vol[k] = 4'hf;
			dma_base[k] = '0;
			dma_next[k] = '0;
			dma_end[k] = '0;
		end
		repeat (2) @(posedge i_clock);
		i_rst <= 1'b0;

		err_mark = errors;
		cpu_read(8'h00, rd);
		check_word("o_rdata", rd, 32'd17);
		cpu_read(8'h01, rd);
		check_word("o_rdata", rd, 32'd0);
		check_sample("o_output_sample_left", o_output_sample_left, '0);
		check_sample("o_output_sample_right", o_output_sample_right, '0);
		end_test("reset values", err_mark);

		err_mark = errors;
		rate = $urandom;
		cpu_write(8'hf0, rate);
		check_word("o_output_sample_rate", o_output_sample_rate, rate);
		cpu_read(8'h00, rd);
		check_word("o_rdata", rd, rate);
		cpu_write(8'h80, $urandom);
		// Unmapped read keeps the last data
		cpu_read(8'h55, rd);
		check_word("o_rdata", rd, rate);
		check_word("o_output_sample_rate", o_output_sample_rate, rate);
		end_test("rate register", err_mark);

		err_mark = errors;
		c = $urandom % NUM_CHANNELS;
		count = 1 + $urandom % 6;
		setup_channel(c, $urandom & 32'hffff_fffc, count, volume_t'($urandom));
		repeat (STROBE_GAP) @(posedge i_clock);
		repeat (count + 2) play_strobe();
		end_test("single channel", err_mark);

		err_mark = errors;
		range_check = 1'b1;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			setup_channel(k, (word_t'(k) << 20) | ($urandom & 32'h0007_fff0),
				1 + $urandom % 6, volume_t'($urandom));
		end
		repeat (STROBE_GAP) @(posedge i_clock);
		repeat (7) play_strobe();
		range_check = 1'b0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			check_word("last DMA address", dma_next[k], dma_end[k]);
		end
		end_test("all channels", err_mark);

		err_mark = errors;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			setup_channel(k, $urandom & 32'hffff_fffc, 3 + $urandom % 4, volume_t'($urandom));
		end
		repeat (STROBE_GAP) @(posedge i_clock);
		c = $urandom % NUM_CHANNELS;
		for (int i = 0; i < 8; i++) begin
			cpu_read(8'h01, rd);
			check_mask("o_rdata busy", chan_mask_t'(rd), model_busy());
			if (i == 2) begin
				setup_channel(c, $urandom & 32'hffff_fffc, 2 + $urandom % 4, m_vol[c]);
				repeat (STROBE_GAP) @(posedge i_clock);
			end
			play_strobe();
		end
		cpu_read(8'h01, rd);
		check_word("o_rdata", rd, word_t'(model_busy()));
		end_test("busy and restart", err_mark);

		errors += u_dut.u_chk.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tb/audio_chk.sv */
`timescale 1ns/1ps

module audio_chk import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,
	input logic i_request,
	input logic o_ready,
	input logic o_dma_request,
	input word_t o_dma_address,
	input logic i_dma_ready
);

	int fail_count = 0;

	// Address holds while the memory makes the master wait
	dma_addr_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		o_dma_request && !i_dma_ready |=> $stable(o_dma_address))
	else begin
		$error("o_dma_address changed while o_dma_request waited");
		fail_count++;
	end

	ready_falls_late: assert property (@(posedge i_clock) disable iff (i_rst)
		$fell(o_ready) |-> $past(!i_request))
	else begin
		$error("o_ready fell while i_request was still high");
		fail_count++;
	end

	dma_idle_in_reset: assert property (@(posedge i_clock) i_rst |=> !o_dma_request)
	else begin
		$error("o_dma_request high during reset");
		fail_count++;
	end

endmodule

bind audio_controller audio_chk u_chk (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_request(i_request),
	.o_ready(o_ready),
	.o_dma_request(o_dma_request),
	.o_dma_address(o_dma_address),
	.i_dma_ready(i_dma_ready)
);

/* hdl/audio_controller.sv */
`timescale 1ns/1ps

module audio_controller import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,

	input logic i_request,
	input logic i_rw,
	input reg_addr_t i_address,
	input word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,

	output logic o_dma_request,
	output word_t o_dma_address,
	input logic i_dma_ready,
	input word_t i_dma_rdata,

	input logic i_output_sample_clock,
	output word_t o_output_sample_rate,
	output sample_t o_output_sample_left,
	output sample_t o_output_sample_right
);

	chan_mask_t setup_strobe;
	word_t setup_address [NUM_CHANNELS];
	count_t setup_count [NUM_CHANNELS];
	volume_t volume [NUM_CHANNELS];

	chan_mask_t busy;
	chan_mask_t dma_req;
	chan_mask_t dma_grant_ready;
	word_t dma_addr [NUM_CHANNELS];
	sample_t ch_left [NUM_CHANNELS];
	sample_t ch_right [NUM_CHANNELS];

	audio_reg_decode u_decode (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_busy(busy),
		.o_setup_strobe(setup_strobe),
		.o_setup_address(setup_address),
		.o_setup_count(setup_count),
		.o_volume(volume),
		.o_sample_rate(o_output_sample_rate)
	);

	for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_rst(i_rst),
			.i_setup_strobe(setup_strobe[g]),
			.i_setup_address(setup_address[g]),
			.i_setup_count(setup_count[g]),
			.i_volume(volume[g]),
			.o_dma_req(dma_req[g]),
			.o_dma_addr(dma_addr[g]),
			.i_dma_ready(dma_grant_ready[g]),
			.i_dma_rdata(i_dma_rdata),
			.i_sample_strobe(i_output_sample_clock),
			.o_busy(busy[g]),
			.o_left(ch_left[g]),
			.o_right(ch_right[g])
		);
	end

	audio_dma_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_req(dma_req),
		.i_addr(dma_addr),
		.o_grant_ready(dma_grant_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_left(ch_left),
		.i_right(ch_right),
		.o_left(o_output_sample_left),
		.o_right(o_output_sample_right)
	);

endmodule

/* hdl/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,

	input sample_t i_left [NUM_CHANNELS],
	input sample_t i_right [NUM_CHANNELS],
	output sample_t o_left,
	output sample_t o_right
);

	sample_t sum_left;
	sample_t sum_right;

	// Sum wraps at 16 bits, no saturation
	always_comb begin
		sum_left = '0;
		sum_right = '0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			sum_left = sum_left + i_left[k];
			sum_right = sum_right + i_right[k];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_left <= '0;
			o_right <= '0;
		end else begin
			o_left <= sum_left;
			o_right <= sum_right;
		end
	end

endmodule

/* hdl/audio_dma_arbiter.sv */
`timescale 1ns/1ps

module audio_dma_arbiter import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,

	input chan_mask_t i_req,
	input word_t i_addr [NUM_CHANNELS],
	output chan_mask_t o_grant_ready,

	output logic o_dma_request,
	output word_t o_dma_address,
	input logic i_dma_ready
);

	chan_idx_t ptr;
	chan_idx_t grant_idx;
	chan_idx_t pick_idx;
	logic pick_valid;

	// First requester at or after the pointer
	always_comb begin
		chan_idx_t cand;
		pick_valid = 1'b0;
		pick_idx = ptr;
		for (int k = NUM_CHANNELS - 1; k >= 0; k--) begin
			cand = ptr + chan_idx_t'(k);
			if (i_req[cand]) begin
				pick_valid = 1'b1;
				pick_idx = cand;
			end
		end
	end

	assign o_grant_ready = (o_dma_request && i_dma_ready) ? chan_mask_t'(1) << grant_idx : '0;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_dma_request <= 1'b0;
			ptr <= '0;
		end else if (!o_dma_request) begin
			o_dma_request <= pick_valid;
		end else if (i_dma_ready) begin
			o_dma_request <= 1'b0;
			ptr <= grant_idx + 1'b1;
		end
	end

	// Address is latched at grant and held for the whole transfer
	always_ff @(posedge i_clock) begin
		if (!o_dma_request) begin
			grant_idx <= pick_idx;
			o_dma_address <= i_addr[pick_idx];
		end
	end

endmodule

/* audio_channel/audio_channel.sv */
`timescale 1ns/1ps

module audio_channel import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,

	input logic i_setup_strobe,
	input word_t i_setup_address,
	input count_t i_setup_count,
	input volume_t i_volume,

	output logic o_dma_req,
	output word_t o_dma_addr,
	input logic i_dma_ready,
	input word_t i_dma_rdata,

	input logic i_sample_strobe,
	output logic o_busy,
	output sample_t o_left,
	output sample_t o_right
);

	chan_state_t state;
	word_t address;
	count_t remaining;
	word_t buffer;
	logic stale;
	logic fill;

	sample_t buf_left;
	sample_t buf_right;
	logic signed [SAMPLE_W+VOLUME_W:0] prod_left;
	logic signed [SAMPLE_W+VOLUME_W:0] prod_right;

	assign o_dma_req = (state == CH_FETCH);
	assign o_dma_addr = address;
	assign o_busy = (state != CH_IDLE);

	// A restart drops the data of a fetch already in flight
	assign fill = (state == CH_FETCH) && i_dma_ready && !stale && !i_setup_strobe;

	// Stereo pair, left in the low half
	assign buf_left = buffer[SAMPLE_W-1:0];
	assign buf_right = buffer[2*SAMPLE_W-1:SAMPLE_W];
	assign prod_left = buf_left * $signed({1'b0, i_volume});
	assign prod_right = buf_right * $signed({1'b0, i_volume});

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= CH_IDLE;
			stale <= 1'b0;
			o_left <= '0;
			o_right <= '0;
		end else begin
			if (i_setup_strobe) begin
				state <= (i_setup_count != '0) ? CH_FETCH : CH_IDLE;
				stale <= (stale || state == CH_FETCH) && !i_dma_ready;
			end else begin
				if (i_dma_ready) begin
					stale <= 1'b0;
				end
				case (state)
					CH_FETCH: if (fill) state <= CH_FULL;
					CH_FULL: if (i_sample_strobe) begin
						state <= (remaining != '0) ? CH_FETCH : CH_IDLE;
					end
					default: ;
				endcase
			end
			// Underrun plays silence
			if (i_sample_strobe) begin
				o_left <= (state == CH_FULL) ? sample_t'(prod_left >>> VOLUME_W) : '0;
				o_right <= (state == CH_FULL) ? sample_t'(prod_right >>> VOLUME_W) : '0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_setup_strobe) begin
			address <= i_setup_address;
			remaining <= i_setup_count;
		end else if (fill) begin
			address <= address + BYTES_PER_WORD;
			remaining <= remaining - 1'b1;
			buffer <= i_dma_rdata;
		end
	end

endmodule

/* hdl/audio_reg_decode.sv */
`timescale 1ns/1ps

module audio_reg_decode import audio_pkg::*; (
	input logic i_clock,
	input logic i_rst,

	input logic i_request,
	input logic i_rw,
	input reg_addr_t i_address,
	input word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,

	input chan_mask_t i_busy,
	output chan_mask_t o_setup_strobe,
	output word_t o_setup_address [NUM_CHANNELS],
	output count_t o_setup_count [NUM_CHANNELS],
	output volume_t o_volume [NUM_CHANNELS],
	output word_t o_sample_rate
);

	chan_idx_t ch_sel;
	logic [1:0] reg_off;
	logic access;
	logic chan_write;

	assign ch_sel = i_address[2 +: $bits(chan_idx_t)];
	assign reg_off = i_address[1:0];

	// New access only while the previous one is not being acknowledged
	assign access = i_request && !o_ready;

	// Channel blocks sit at 00..0F
	assign chan_write = access && i_rw && (i_address[REG_ADDR_W-1:4] == '0);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_setup_strobe <= '0;
			o_sample_rate <= DEFAULT_SAMPLE_RATE;
			for (int k = 0; k < NUM_CHANNELS; k++) begin
				o_volume[k] <= DEFAULT_VOLUME;
			end
		end else begin
			o_setup_strobe <= '0;
			if (access) begin
				o_ready <= 1'b1;
				// Count write starts the channel
				if (chan_write && reg_off == REG_CH_COUNT) begin
					o_setup_strobe[ch_sel] <= 1'b1;
				end
				if (chan_write && reg_off == REG_CH_VOLUME) begin
					o_volume[ch_sel] <= i_wdata[VOLUME_W-1:0];
				end
				if (i_rw && i_address == REG_RATE_W) begin
					o_sample_rate <= i_wdata;
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (chan_write && reg_off == REG_CH_ADDR) begin
			o_setup_address[ch_sel] <= i_wdata;
		end
		if (chan_write && reg_off == REG_CH_COUNT) begin
			o_setup_count[ch_sel] <= i_wdata[COUNT_W-1:0];
		end
		// Unmapped reads keep the last data
		if (access && !i_rw) begin
			case (i_address)
				REG_RATE_R: o_rdata <= o_sample_rate;
				REG_BUSY_R: o_rdata <= word_t'(i_busy);
				default: ;
			endcase
		end
	end

endmodule

/* common/audio_pkg.sv */
package audio_pkg;

	localparam int NUM_CHANNELS = 4;

	localparam int REG_ADDR_W = 8;
	localparam int DATA_W = 32;
	localparam int SAMPLE_W = 16;
	localparam int COUNT_W = 24;
	localparam int VOLUME_W = 4;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [VOLUME_W-1:0] volume_t;
	typedef logic [NUM_CHANNELS-1:0] chan_mask_t;
	typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_idx_t;

	// Buffer state of one channel
	typedef enum logic [1:0] {
		CH_IDLE,
		CH_FETCH,
		CH_FULL
	} chan_state_t;

	// Offsets inside a channel's block of four registers
	localparam logic [1:0] REG_CH_ADDR = 2'd0;
	localparam logic [1:0] REG_CH_COUNT = 2'd1;
	localparam logic [1:0] REG_CH_VOLUME = 2'd2;

	localparam reg_addr_t REG_RATE_W = 8'hf0;
	localparam reg_addr_t REG_RATE_R = 8'h00;
	localparam reg_addr_t REG_BUSY_R = 8'h01;

	// 100 MHz / (256 * 22050)
	localparam word_t DEFAULT_SAMPLE_RATE = 32'd17;
	localparam volume_t DEFAULT_VOLUME = 4'hf;
	localparam word_t BYTES_PER_WORD = 32'd4;

endpackage
